/* rtl/mem_pkg.sv */
`default_nettype none

// ==========================================================================
// Data bus and data RAM constants
// ==========================================================================

package mem_pkg;

	// Access width codes carried on the width field of a memory operation.
	localparam logic [1:0] width_byte = 2'd0;
	localparam logic [1:0] width_half = 2'd1;
	localparam logic [1:0] width_word = 2'd2;	// Code 3 is also treated as a word.

	// The RAM is word addressed, so the bus carries address bits [31:2].
	localparam int ram_addr_bits = 8;
	localparam int ram_words = 256;	// Anything at or above this index is an error.

endpackage

`default_nettype wire

/* rtl/isa_pkg.sv */
`default_nettype none

// ==========================================================================
// Instruction encodings
// ==========================================================================

package isa_pkg;

	// Opcode lives in the top two bits of every instruction.
	localparam logic [1:0] op_nop = 2'b00;
	localparam logic [1:0] op_load = 2'b01;
	localparam logic [1:0] op_store = 2'b10;
	localparam logic [1:0] op_movi = 2'b11;

	localparam int num_regs = 16;
	localparam int reg_bits = 4;

	// An instruction word is read either as a memory operation or as a
	// move-immediate. The op field sits in the same place in both views.
	typedef union packed {
		struct packed {
			logic [1:0] op;
			logic [1:0] width;
			logic [3:0] rd;
			logic [23:0] addr;	// Byte address.
		} mem;
		struct packed {
			logic [1:0] op;
			logic [3:0] rd;
			logic [25:0] imm;
		} movi;
	} instr_u;

endpackage

`default_nettype wire

/* rtl/op_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module op_issue (
	input wire clk,
	input wire rst,
	input wire [31:0] instr,
	input wire instr_valid,
	input wire [31:0] store_data,
	input wire complete,
	output logic ready,
	output logic load,
	output logic store,
	output logic [31:0] addr,
	output logic [31:0] mdr,
	output logic [1:0] width,
	output logic [isa_pkg::reg_bits-1:0] rd_sel,
	output logic update_rd,
	output logic [31:0] wr_val
);

	isa_pkg::instr_u in_word;
	isa_pkg::instr_u cur;	// The accepted instruction.
	logic accept;

	assign in_word = instr;
	assign accept = instr_valid & ready;

	// A move-immediate holds off the next instruction for one cycle only.
	assign ready = ~(load | store | update_rd);

	always_ff @(posedge clk) begin
		if (accept) begin
			cur <= in_word;
			mdr <= store_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			load <= 1'b0;
			store <= 1'b0;
			update_rd <= 1'b0;
		end else begin
			update_rd <= accept && in_word.movi.op == isa_pkg::op_movi;

			// The strobes are held until the bus reports ack or error.
			if (accept) begin
				load <= in_word.mem.op == isa_pkg::op_load;
				store <= in_word.mem.op == isa_pkg::op_store;
			end else if (complete) begin
				load <= 1'b0;
				store <= 1'b0;
			end
		end
	end

	assign addr = {8'b0, cur.mem.addr};
	assign width = cur.mem.width;
	assign wr_val = {6'b0, cur.movi.imm};

	// The destination field is in a different place in the two formats.
	always_comb begin
		if (cur.movi.op == isa_pkg::op_movi)
			rd_sel = cur.movi.rd;
		else
			rd_sel = cur.mem.rd;
	end

endmodule

`default_nettype wire

/* rtl/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
	input wire clk,
	input wire rst,
	input wire load,
	input wire store,
	input wire [31:0] addr,
	input wire [31:0] mdr,
	input wire [1:0] width,
	input wire [31:0] wr_val,
	input wire update_rd,
	input wire [isa_pkg::reg_bits-1:0] rd_sel,
	output logic [31:0] reg_wr_val,
	output logic update_rd_out,
	output logic [isa_pkg::reg_bits-1:0] rd_sel_out,
	output logic complete,
	output logic data_abort,
	// Data bus.
	output logic [29:0] d_addr,
	output logic [3:0] d_bytesel,
	output logic d_wr_en,
	output logic [31:0] d_wr_val,
	output logic d_access,
	input wire [31:0] d_data,
	input wire d_ack,
	input wire d_error
);

	logic [1:0] lane;
	logic [31:0] mem_rd_val;
	logic access_q;	// The bus has taken the current strobe.
	logic mem_update_rd;
	logic [isa_pkg::reg_bits-1:0] mem_rd;
	logic update_rd_bypass;
	logic [isa_pkg::reg_bits-1:0] rd_sel_bypass;
	logic [31:0] wr_val_bypass;

	assign lane = addr[1:0];
	assign d_addr = addr[31:2];
	assign d_wr_en = store;

	// The strobes are levels, but the bus sees one access per operation.
	assign d_access = (load | store) & ~access_q;

	assign complete = d_ack | d_error;
	assign data_abort = d_error;

	// ======================================================================
	// Result selection
	// ======================================================================

	assign reg_wr_val = complete ? mem_rd_val : wr_val_bypass;
	assign rd_sel_out = complete ? mem_rd : rd_sel_bypass;
	assign update_rd_out = (complete && !d_error) ? mem_update_rd : update_rd_bypass;

	always_ff @(posedge clk) begin
		if (rst) begin
			access_q <= 1'b0;
			mem_update_rd <= 1'b0;
			update_rd_bypass <= 1'b0;
		end else begin
			update_rd_bypass <= update_rd;

			if (complete) begin
				access_q <= 1'b0;
				mem_update_rd <= 1'b0;
			end else if (d_access) begin
				access_q <= 1'b1;
				mem_update_rd <= load;	// Stores write no register.
			end
		end
	end

	always_ff @(posedge clk) begin
		wr_val_bypass <= wr_val;
		rd_sel_bypass <= rd_sel;
		if (d_access && load)
			mem_rd <= rd_sel;
	end

	// ======================================================================
	// Byte lanes
	// ======================================================================

	// Write data is moved up onto its lanes, read data is moved down and
	// masked so that sub-word loads come back zero-extended.
	always_comb begin
		case (width)
		mem_pkg::width_byte: begin
			d_bytesel = 4'b0001 << lane;
			d_wr_val = mdr << {lane, 3'b000};
			mem_rd_val = (d_data >> {lane, 3'b000}) & 32'h0000_00ff;
		end
		mem_pkg::width_half: begin
			d_bytesel = 4'b0011 << {lane[1], 1'b0};
			d_wr_val = mdr << {lane[1], 4'b0000};
			mem_rd_val = (d_data >> {lane[1], 4'b0000}) & 32'h0000_ffff;
		end
		mem_pkg::width_word: begin
			d_bytesel = 4'b1111;
			d_wr_val = mdr;
			mem_rd_val = d_data;
		end
		default: begin
			d_bytesel = 4'b1111;
			d_wr_val = mdr;
			mem_rd_val = d_data;
		end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
	input wire clk,
	input wire rst,
	input wire [29:0] d_addr,
	input wire [3:0] d_bytesel,
	input wire d_wr_en,
	input wire [31:0] d_wr_val,
	input wire d_access,
	output logic [31:0] d_data,
	output logic d_ack,
	output logic d_error
);

	logic [31:0] mem [mem_pkg::ram_words];
	logic in_range;
	logic [mem_pkg::ram_addr_bits-1:0] idx;

	assign in_range = d_addr < 30'(mem_pkg::ram_words);
	assign idx = d_addr[mem_pkg::ram_addr_bits-1:0];

	initial begin
		for (int i = 0; i < mem_pkg::ram_words; i++)
			mem[i] = 32'h0;
	end

	// Out of range accesses leave the array alone.
	always @(posedge clk) begin
		if (d_access && in_range) begin
			if (d_wr_en) begin
				for (int i = 0; i < 4; i++) begin
					if (d_bytesel[i])
						mem[idx][i*8 +: 8] <= d_wr_val[i*8 +: 8];
				end
			end else begin
				d_data <= mem[idx];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			d_ack <= 1'b0;
			d_error <= 1'b0;
		end else begin
			d_ack <= d_access & in_range;
			d_error <= d_access & ~in_range;	// The error lasts one cycle like the ack.
		end
	end

endmodule

`default_nettype wire

/* rtl/reg_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_writeback (
	input wire clk,
	input wire rst,
	input wire update_rd_out,
	input wire [isa_pkg::reg_bits-1:0] rd_sel_out,
	input wire [31:0] reg_wr_val,
	input wire [isa_pkg::reg_bits-1:0] rf_rd_sel,
	output logic [31:0] rf_rd_val
);

	logic [31:0] regs [isa_pkg::num_regs];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < isa_pkg::num_regs; i++)
				regs[i] <= 32'h0;
		end else if (update_rd_out) begin
			regs[rd_sel_out] <= reg_wr_val;
		end
	end

	assign rf_rd_val = regs[rf_rd_sel];	// Read port shows the old value during a write.

endmodule

`default_nettype wire

/* rtl/mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys (
	input wire clk,
	input wire rst,
	input wire [31:0] instr,
	input wire instr_valid,
	input wire [31:0] store_data,
	input wire [isa_pkg::reg_bits-1:0] rf_rd_sel,
	output wire ready,
	output wire data_abort,
	output wire [31:0] rf_rd_val
);

	// Issue to memory stage.
	wire load;
	wire store;
	wire [31:0] addr;
	wire [31:0] mdr;
	wire [1:0] width;
	wire [isa_pkg::reg_bits-1:0] rd_sel;
	wire update_rd;
	wire [31:0] wr_val;
	wire complete;

	// Memory stage to register file.
	wire [31:0] reg_wr_val;
	wire update_rd_out;
	wire [isa_pkg::reg_bits-1:0] rd_sel_out;

	// Data bus.
	wire [29:0] d_addr;
	wire [3:0] d_bytesel;
	wire d_wr_en;
	wire [31:0] d_wr_val;
	wire d_access;
	wire [31:0] d_data;
	wire d_ack;
	wire d_error;

	op_issue u_issue (
		.clk(clk), .rst(rst),
		.instr(instr), .instr_valid(instr_valid), .store_data(store_data),
		.complete(complete), .ready(ready),
		.load(load), .store(store), .addr(addr), .mdr(mdr), .width(width),
		.rd_sel(rd_sel), .update_rd(update_rd), .wr_val(wr_val)
	);

	mem_stage u_mem (
		.clk(clk), .rst(rst),
		.load(load), .store(store), .addr(addr), .mdr(mdr), .width(width),
		.wr_val(wr_val), .update_rd(update_rd), .rd_sel(rd_sel),
		.reg_wr_val(reg_wr_val), .update_rd_out(update_rd_out),
		.rd_sel_out(rd_sel_out), .complete(complete), .data_abort(data_abort),
		.d_addr(d_addr), .d_bytesel(d_bytesel), .d_wr_en(d_wr_en),
		.d_wr_val(d_wr_val), .d_access(d_access),
		.d_data(d_data), .d_ack(d_ack), .d_error(d_error)
	);

	data_ram u_ram (
		.clk(clk), .rst(rst),
		.d_addr(d_addr), .d_bytesel(d_bytesel), .d_wr_en(d_wr_en),
		.d_wr_val(d_wr_val), .d_access(d_access),
		.d_data(d_data), .d_ack(d_ack), .d_error(d_error)
	);

	reg_writeback u_regs (
		.clk(clk), .rst(rst),
		.update_rd_out(update_rd_out), .rd_sel_out(rd_sel_out),
		.reg_wr_val(reg_wr_val),
		.rf_rd_sel(rf_rd_sel), .rf_rd_val(rf_rd_val)
	);

endmodule

`default_nettype wire

/* verif/tb_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

	localparam int total_instrs = 16 + 20 + 38 + 12 + 9 + 300;	// Sum over the six tests.
	localparam int cycle_limit = 4 * total_instrs * 3;	// A memory op needs three cycles.
	localparam logic [23:0] junk_addr = 24'h3fc;	// Target of the stores offered while held off.

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic instr_valid;
	logic [31:0] store_data;
	logic [isa_pkg::reg_bits-1:0] rf_rd_sel;
	wire ready;
	wire data_abort;
	wire [31:0] rf_rd_val;

	logic [31:0] model_ram [mem_pkg::ram_words];
	logic [31:0] model_regs [isa_pkg::num_regs];
	logic [31:0] lfsr;
	logic abort_seen;
	string test_name;
	int errors;
	int checks;
	int cycles = 0;

	mem_subsys dut (
		.clk(clk), .rst(rst),
		.instr(instr), .instr_valid(instr_valid), .store_data(store_data),
		.rf_rd_sel(rf_rd_sel), .ready(ready), .data_abort(data_abort),
		.rf_rd_val(rf_rd_val)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("tests failed");
			$finish;
		end
	end

	// ======================================================================
	// Stimulus and model helpers
	// ======================================================================

	// The Galois LFSR takes one step for every bit handed out.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = 32'h0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			val = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic logic [31:0] mem_word(input logic [1:0] op, input logic [1:0] w,
			input logic [3:0] rd, input logic [23:0] a);
		return {op, w, rd, a};
	endfunction

	function automatic logic [31:0] movi_word(input logic [3:0] rd, input logic [25:0] imm);
		return {isa_pkg::op_movi, rd, imm};
	endfunction

	// Sub-word reads come back zero-extended from their lane.
	function automatic logic [31:0] lane_read(input logic [31:0] word, input logic [1:0] w,
			input logic [1:0] off);
		case (w)
		mem_pkg::width_byte: return {24'h0, word[off*8 +: 8]};
		mem_pkg::width_half: return {16'h0, word[off[1]*16 +: 16]};
		default: return word;
		endcase
	endfunction

	function automatic logic [31:0] lane_write(input logic [31:0] word, input logic [31:0] data,
			input logic [1:0] w, input logic [1:0] off);
		logic [31:0] res;
		res = word;
		case (w)
		mem_pkg::width_byte: res[off*8 +: 8] = data[7:0];
		mem_pkg::width_half: res[off[1]*16 +: 16] = data[15:0];
		default: res = data;
		endcase
		return res;
	endfunction

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("Fail %s (%s): expected %08h, actual %08h", test_name, what, exp, act);
		end
	endtask

	task automatic check_reg(input logic [3:0] r, input string what);
		@(posedge clk);
		#1;
		rf_rd_sel = r;
		@(negedge clk);
		check_val(what, model_regs[r], rf_rd_val);
		@(posedge clk);
		#1;
	endtask

	task automatic check_all_regs();
		for (int i = 0; i < isa_pkg::num_regs; i++)
			check_reg(4'(i), "register file");
	endtask

	// Called 1 ns after an edge; returns 1 ns after the accepting edge.
	task automatic drive_instr(input logic [31:0] word, input logic [31:0] data);
		while (!ready) begin
			@(posedge clk);
			#1;
		end
		instr = word;
		store_data = data;
		instr_valid = 1'b1;
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
	endtask

	task automatic wait_idle();
		abort_seen = 1'b0;
		while (!ready) begin
			if (data_abort)
				abort_seen = 1'b1;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic offer_held(input logic [31:0] word);
		checks++;
		assert (!ready) else begin
			errors++;
			$display("ready was high while a held-off instruction was offered");
		end
		instr = word;
		store_data = 32'hffff_ffff;	// A store taken by mistake would leave all ones.
		instr_valid = 1'b1;
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
	endtask

	// A nonzero held word is offered while the operation is outstanding.
	task automatic do_mem(input logic [1:0] op, input logic [1:0] w, input logic [3:0] rd,
			input logic [23:0] a, input logic [31:0] data, input logic [31:0] held);
		logic in_range;
		logic [7:0] idx;
		in_range = a < 24'd1024;
		idx = a[9:2];
		drive_instr(mem_word(op, w, rd, a), data);
		if (held != 32'h0)
			offer_held(held);
		wait_idle();
		check_val("data_abort", {31'h0, ~in_range}, {31'h0, abort_seen});
		if (in_range && op == isa_pkg::op_store)
			model_ram[idx] = lane_write(model_ram[idx], data, w, a[1:0]);
		if (in_range && op == isa_pkg::op_load)
			model_regs[rd] = lane_read(model_ram[idx], w, a[1:0]);
	endtask

	task automatic do_movi(input logic [3:0] rd, input logic [25:0] imm);
		drive_instr(movi_word(rd, imm), 32'h0);
		wait_idle();
		model_regs[rd] = {6'h0, imm};
	endtask

	task automatic do_nop();
		drive_instr({isa_pkg::op_nop, 30'(rand_bits(30))}, 32'h0);
		checks++;
		assert (ready) else begin
			errors++;
			$display("ready went low after a nop was accepted");
		end
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic movi_write();
		test_name = "movi_write";
		for (int i = 0; i < isa_pkg::num_regs; i++)
			do_movi(4'(i), 26'(rand_bits(26)));
		check_all_regs();
	endtask

	task automatic word_roundtrip();
		logic [23:0] a;
		logic [3:0] rd;
		test_name = "word_roundtrip";
		for (int i = 0; i < 10; i++) begin
			a = {14'h0, 8'(rand_bits(8)), 2'b00};
			rd = 4'(rand_bits(4));
			do_mem(isa_pkg::op_store, mem_pkg::width_word, 4'd0, a, rand_bits(32), 32'h0);
			do_mem(isa_pkg::op_load, mem_pkg::width_word, rd, a, 32'h0, 32'h0);
			check_reg(rd, "loaded word");
		end
	endtask

	task automatic sub_word_lanes();
		logic [23:0] a;
		test_name = "sub_word_lanes";
		for (int k = 0; k < 2; k++) begin
			a = {14'h0, 8'(rand_bits(8)), 2'b00};
			do_mem(isa_pkg::op_store, mem_pkg::width_word, 4'd0, a, rand_bits(32), 32'h0);
			for (int off = 0; off < 4; off++)
				do_mem(isa_pkg::op_store, mem_pkg::width_byte, 4'd0, a | 24'(off),
					rand_bits(32), 32'h0);
			do_mem(isa_pkg::op_load, mem_pkg::width_word, 4'd1, a, 32'h0, 32'h0);
			check_reg(4'd1, "word after byte stores");
			for (int off = 0; off < 4; off++)
				do_mem(isa_pkg::op_store, mem_pkg::width_half, 4'd0, a | 24'(off),
					rand_bits(32), 32'h0);
			do_mem(isa_pkg::op_load, mem_pkg::width_word, 4'd2, a, 32'h0, 32'h0);
			check_reg(4'd2, "word after half stores");
			for (int off = 0; off < 4; off++) begin
				do_mem(isa_pkg::op_load, mem_pkg::width_byte, 4'd3, a | 24'(off), 32'h0, 32'h0);
				check_reg(4'd3, "byte load");
			end
			for (int off = 0; off < 4; off++) begin
				do_mem(isa_pkg::op_load, mem_pkg::width_half, 4'd4, a | 24'(off), 32'h0, 32'h0);
				check_reg(4'd4, "half load");
			end
		end
	endtask

	task automatic abort_no_write();
		logic [23:0] oob;
		logic [3:0] r;
		test_name = "abort_no_write";
		for (int i = 0; i < 3; i++) begin
			r = 4'(5 + i);
			oob = (i == 0) ? 24'd1024 : 24'd1024 + 24'(rand_bits(20));
			do_movi(r, 26'(rand_bits(26)));
			do_mem(isa_pkg::op_load, mem_pkg::width_word, r, oob, 32'h0, 32'h0);
			check_reg(r, "destination after abort");
			do_mem(isa_pkg::op_store, mem_pkg::width_word, 4'd0, oob, rand_bits(32), 32'h0);
			// The low address bits alias an in-range word that must be untouched.
			do_mem(isa_pkg::op_load, mem_pkg::width_word, 4'(8 + i), {14'h0, oob[9:2], 2'b00},
				32'h0, 32'h0);
			check_reg(4'(8 + i), "aliased word");
		end
	endtask

	task automatic ready_hold();
		logic [23:0] a;
		test_name = "ready_hold";
		do_movi(4'd15, 26'h2aa_aaaa);
		do_mem(isa_pkg::op_store, mem_pkg::width_word, 4'd0, junk_addr, 32'h0, 32'h0);
		for (int i = 0; i < 3; i++) begin
			a = {16'h0, 6'(rand_bits(6)), 2'b00};
			do_mem(isa_pkg::op_store, mem_pkg::width_word, 4'd0, a, rand_bits(32),
				movi_word(4'd15, 26'h3ff_ffff));
			do_mem(isa_pkg::op_load, mem_pkg::width_word, 4'(i), a, 32'h0,
				mem_word(isa_pkg::op_store, mem_pkg::width_word, 4'd0, junk_addr));
			check_reg(4'(i), "accepted load");
		end
		check_reg(4'd15, "register behind ignored movi");
		do_mem(isa_pkg::op_load, mem_pkg::width_word, 4'd14, junk_addr, 32'h0, 32'h0);
		check_reg(4'd14, "word behind ignored store");
	endtask

	task automatic random_mix();
		logic [1:0] op;
		logic [3:0] rd;
		logic [23:0] a;
		test_name = "random_mix";
		for (int n = 0; n < 300; n++) begin
			op = 2'(rand_bits(2));
			rd = 4'(rand_bits(4));
			if (op == isa_pkg::op_nop) begin
				do_nop();
			end else if (op == isa_pkg::op_movi) begin
				do_movi(rd, 26'(rand_bits(26)));
			end else begin
				if (3'(rand_bits(3)) == 3'd0)
					a = 24'd1024 + 24'(rand_bits(16));	// About one access in eight misses.
				else
					a = 24'(rand_bits(6));
				do_mem(op, 2'(rand_bits(2)), rd, a, rand_bits(32), 32'h0);
			end
		end
		check_all_regs();
	endtask

	initial begin
		rst = 1'b1;
		instr = 32'h0;
		instr_valid = 1'b0;
		store_data = 32'h0;
		rf_rd_sel = '0;
		lfsr = 32'd55;
		abort_seen = 1'b0;
		errors = 0;
		checks = 0;
		for (int i = 0; i < mem_pkg::ram_words; i++)
			model_ram[i] = 32'h0;
		for (int i = 0; i < isa_pkg::num_regs; i++)
			model_regs[i] = 32'h0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		movi_write();
		word_roundtrip();
		sub_word_lanes();
		abort_no_write();
		ready_hold();
		random_mix();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* mem_subsys.f */
rtl/mem_pkg.sv
rtl/isa_pkg.sv
rtl/op_issue.sv
rtl/mem_stage.sv
rtl/data_ram.sv
rtl/reg_writeback.sv
rtl/mem_subsys.sv
verif/tb_mem_subsys.sv

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator and run; the result is taken from the simulator output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mem_subsys.f --top-module tb_mem_subsys \
	-o sim_mem_subsys \
	&& ./obj_dir/sim_mem_subsys | tee /dev/stderr | grep -qx "all tests passed" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
